//--- rtl/pe_macros.svh
// ====================
// widths, memory map and PageRank constants for the processing element
// include before pe_pkg and in every RTL file that needs them
// ====================
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// datapath widths
`define PE_IDX_W        8
`define PE_DELTA_W      16
`define PE_ADDR_W       16
`define PE_DATA_W       32

// word-address map of the shared memory
`define PE_VERTEX_BASE  16'h0000
`define PE_ROWPTR_BASE  16'h0100
`define PE_COLIDX_BASE  16'h0200

// propagation threshold on delta
`define PE_THRESH       16'd64
// damping factor out of 256, about 0.85
`define PE_DAMP         8'd217

`endif

//--- rtl/pe_pkg.sv
// ====================
// shared types of the processing element
// events, bus requests and the two views of an edge-memory word
// ====================
`include "pe_macros.svh"

package pe_pkg;

    // ====================
    // events
    // ====================

    // same layout for incoming and propagate events
    typedef struct packed {
        logic [`PE_IDX_W-1:0]   idx;
        logic [`PE_DELTA_W-1:0] delta;
    } pe_event_t;

    // unsigned fixed point vertex value
    typedef logic [`PE_DELTA_W-1:0] vertex_val_t;

    // ====================
    // memory side
    // ====================

    // one requester's transfer towards the arbiter
    typedef struct packed {
        logic [`PE_ADDR_W-1:0] addr;
        logic                  write;
        logic [`PE_DATA_W-1:0] wdata;
    } bus_req_t;

    // edge memory word
    // rowptr: pointer of the even vertex in [0], odd vertex in [1]
    // colidx: neighbour of position 4k+n in byte n
    typedef union packed {
        logic [1:0][15:0]           rowptr;
        logic [3:0][`PE_IDX_W-1:0]  colidx;
    } edge_word_t;

endpackage

//--- rtl/bus_arbiter.sv
// ====================
// fixed-priority arbiter and APB master for the two bus requesters
// vertex updater wins ties, one transfer at a time
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module bus_arbiter
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  bus_req_t              vu_req_i,
    input  logic                  vu_valid_i,
    output logic                  vu_done_o,
    input  bus_req_t              ew_req_i,
    input  logic                  ew_valid_i,
    output logic                  ew_done_o,
    output logic [`PE_DATA_W-1:0] rdata_o,
    output logic [`PE_ADDR_W-1:0] paddr_o,
    output logic                  pwrite_o,
    output logic [`PE_DATA_W-1:0] pwdata_o,
    output logic                  psel_o,
    output logic                  penable_o,
    input  logic [`PE_DATA_W-1:0] prdata_i,
    input  logic                  pready_i
);

    typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS} apb_state_e;

    apb_state_e state_q;
    // 1 when the edge walker owns the bus
    logic       owner_q;
    logic       done_q;
    logic       grant;
    logic       xfer_end;
    bus_req_t   cur_q;

    // owner still holds its old request during the done cycle
    assign grant    = (state_q == S_IDLE) && !done_q && (vu_valid_i || ew_valid_i);
    assign xfer_end = (state_q == S_ACCESS) && pready_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= S_IDLE;
            owner_q <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= xfer_end;
            case (state_q)
                S_IDLE:
                begin
                    if (grant)
                    begin
                        state_q <= S_SETUP;
                        owner_q <= !vu_valid_i;
                    end
                end
                S_SETUP:  state_q <= S_ACCESS;
                S_ACCESS: if (pready_i) state_q <= S_IDLE;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (grant)
            cur_q <= vu_valid_i ? vu_req_i : ew_req_i;
        if (xfer_end)
            rdata_o <= prdata_i;
    end

    assign paddr_o   = cur_q.addr;
    assign pwrite_o  = cur_q.write;
    assign pwdata_o  = cur_q.wdata;
    assign psel_o    = (state_q != S_IDLE);
    assign penable_o = (state_q == S_ACCESS);
    assign vu_done_o = done_q && !owner_q;
    assign ew_done_o = done_q && owner_q;

endmodule

//--- rtl/vertex_updater.sv
// ====================
// read-update-write of one vertex value over the shared bus
// start_i launches it, fin_o marks the completed write-back
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module vertex_updater
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  pe_event_t             ev_i,
    output bus_req_t              req_o,
    output logic                  req_valid_o,
    input  logic                  done_i,
    input  logic [`PE_DATA_W-1:0] rdata_i,
    output logic                  fin_o
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE} vu_state_e;

    vu_state_e   state_q;
    pe_event_t   ev_q;
    vertex_val_t val_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= S_IDLE;
        else
        begin
            case (state_q)
                S_IDLE:  if (start_i) state_q <= S_READ;
                S_READ:  if (done_i) state_q <= S_WRITE;
                S_WRITE: if (done_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (start_i)
            ev_q <= ev_i;
        // value sits in the low half, 16-bit wrap on the sum
        if ((state_q == S_READ) && done_i)
            val_q <= rdata_i[`PE_DELTA_W-1:0] + ev_q.delta;
    end

    assign req_valid_o = (state_q != S_IDLE);
    assign req_o.addr  = `PE_VERTEX_BASE + {{(`PE_ADDR_W-`PE_IDX_W){1'b0}}, ev_q.idx};
    assign req_o.write = (state_q == S_WRITE);
    assign req_o.wdata = {{(`PE_DATA_W-`PE_DELTA_W){1'b0}}, val_q};
    assign fin_o       = (state_q == S_WRITE) && done_i;

endmodule

//--- rtl/edge_walker.sv
// ====================
// adjacency walk of one vertex: row pointers, degree, propagate delta,
// then one propagate event per neighbour in column order
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module edge_walker
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  pe_event_t             ev_i,
    output bus_req_t              req_o,
    output logic                  req_valid_o,
    input  logic                  done_i,
    input  logic [`PE_DATA_W-1:0] rdata_i,
    output pe_event_t             pro_o,
    output logic                  pro_valid_o,
    input  logic                  pro_ready_i,
    output logic                  fin_o
);

    typedef enum logic [2:0] {S_IDLE, S_ROW0, S_ROW1, S_DIV, S_COL, S_EMIT} ew_state_e;

    ew_state_e              state_q;
    logic                   fin_q;
    logic                   odd_q;
    logic [`PE_ADDR_W-1:0]  rp_addr_q;
    // pos_q starts at the first pointer and walks to end_q
    logic [15:0]            pos_q;
    logic [15:0]            end_q;
    logic [`PE_DELTA_W-1:0] num_q;
    logic [`PE_DELTA_W-1:0] pdelta_q;
    edge_word_t             col_q;
    edge_word_t             rp_word;
    logic [`PE_DELTA_W+7:0] damped;
    logic [15:0]            degree;
    logic [15:0]            pos_next;

    assign rp_word  = rdata_i;
    assign damped   = {8'd0, ev_i.delta} * {{`PE_DELTA_W{1'b0}}, `PE_DAMP};
    assign degree   = end_q - pos_q;
    assign pos_next = pos_q + 16'd1;

    // ====================
    // control
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= S_IDLE;
            fin_q   <= 1'b0;
        end
        else
        begin
            fin_q <= 1'b0;
            case (state_q)
                S_IDLE: if (start_i) state_q <= S_ROW0;
                S_ROW0: if (done_i) state_q <= odd_q ? S_ROW1 : S_DIV;
                S_ROW1: if (done_i) state_q <= S_DIV;
                S_DIV:
                begin
                    // sink vertex, nothing to send
                    if (degree == 16'd0)
                    begin
                        state_q <= S_IDLE;
                        fin_q   <= 1'b1;
                    end
                    else
                        state_q <= S_COL;
                end
                S_COL: if (done_i) state_q <= S_EMIT;
                S_EMIT:
                begin
                    if (pro_ready_i)
                    begin
                        if (pos_next == end_q)
                        begin
                            state_q <= S_IDLE;
                            fin_q   <= 1'b1;
                        end
                        else if (pos_next[1:0] == 2'b00)
                            state_q <= S_COL;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ====================
    // datapath
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (start_i)
        begin
            odd_q     <= ev_i.idx[0];
            num_q     <= damped[`PE_DELTA_W+7:8];
            rp_addr_q <= `PE_ROWPTR_BASE
                         + {{(`PE_ADDR_W-`PE_IDX_W+1){1'b0}}, ev_i.idx[`PE_IDX_W-1:1]};
        end
        if ((state_q == S_ROW0) && done_i)
        begin
            // odd vertex finds its end pointer in the next word
            if (odd_q)
            begin
                pos_q     <= rp_word.rowptr[1];
                rp_addr_q <= rp_addr_q + 1'b1;
            end
            else
            begin
                pos_q <= rp_word.rowptr[0];
                end_q <= rp_word.rowptr[1];
            end
        end
        if ((state_q == S_ROW1) && done_i)
            end_q <= rp_word.rowptr[0];
        if ((state_q == S_DIV) && (degree != 16'd0))
            pdelta_q <= num_q / degree;
        if ((state_q == S_COL) && done_i)
            col_q <= rdata_i;
        if ((state_q == S_EMIT) && pro_ready_i)
            pos_q <= pos_next;
    end

    assign req_valid_o = (state_q == S_ROW0) || (state_q == S_ROW1) || (state_q == S_COL);
    assign req_o.addr  = (state_q == S_COL) ? `PE_COLIDX_BASE + {2'b00, pos_q[15:2]}
                                            : rp_addr_q;
    assign req_o.write = 1'b0;
    assign req_o.wdata = '0;

    assign pro_valid_o = (state_q == S_EMIT);
    assign pro_o.idx   = col_q.colidx[pos_q[1:0]];
    assign pro_o.delta = pdelta_q;
    assign fin_o       = fin_q;

endmodule

//--- rtl/event_ctrl.sv
// ====================
// event intake: accepts one event at a time, applies the threshold
// and starts the updater and, above threshold, the edge walker
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module event_ctrl
    import pe_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  pe_event_t ev_i,
    input  logic      ev_valid_i,
    output logic      ev_ready_o,
    output pe_event_t ev_o,
    output logic      vu_start_o,
    output logic      ew_start_o,
    input  logic      vu_fin_i,
    input  logic      ew_fin_i
);

    // one flag per started worker
    logic      vu_pend_q;
    logic      ew_pend_q;
    logic      accept;
    logic      above;
    pe_event_t ev_q;

    // idle means no worker pending
    assign ev_ready_o = !vu_pend_q && !ew_pend_q;
    assign accept     = ev_valid_i && ev_ready_o;
    assign above      = (ev_i.delta > `PE_THRESH);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            vu_pend_q  <= 1'b0;
            ew_pend_q  <= 1'b0;
            vu_start_o <= 1'b0;
            ew_start_o <= 1'b0;
        end
        else
        begin
            vu_start_o <= accept;
            ew_start_o <= accept && above;
            if (accept)
            begin
                vu_pend_q <= 1'b1;
                ew_pend_q <= above;
            end
            else
            begin
                if (vu_fin_i)
                    vu_pend_q <= 1'b0;
                if (ew_fin_i)
                    ew_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept)
            ev_q <= ev_i;
    end

    assign ev_o = ev_q;

endmodule

//--- rtl/pe_top.sv
// ====================
// processing element top: event intake, the two workers and the
// shared APB memory master
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module pe_top
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pe_event_t             ev_i,
    input  logic                  ev_valid_i,
    output logic                  ev_ready_o,
    output pe_event_t             pro_o,
    output logic                  pro_valid_o,
    input  logic                  pro_ready_i,
    output logic [`PE_ADDR_W-1:0] paddr_o,
    output logic                  pwrite_o,
    output logic [`PE_DATA_W-1:0] pwdata_o,
    output logic                  psel_o,
    output logic                  penable_o,
    input  logic [`PE_DATA_W-1:0] prdata_i,
    input  logic                  pready_i
);

    pe_event_t             ev_cur;
    logic                  vu_start;
    logic                  ew_start;
    logic                  vu_fin;
    logic                  ew_fin;
    bus_req_t              vu_req;
    bus_req_t              ew_req;
    logic                  vu_req_valid;
    logic                  ew_req_valid;
    logic                  vu_done;
    logic                  ew_done;
    logic [`PE_DATA_W-1:0] rdata;

    event_ctrl u_event_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ev_i       (ev_i),
        .ev_valid_i (ev_valid_i),
        .ev_ready_o (ev_ready_o),
        .ev_o       (ev_cur),
        .vu_start_o (vu_start),
        .ew_start_o (ew_start),
        .vu_fin_i   (vu_fin),
        .ew_fin_i   (ew_fin)
    );

    vertex_updater u_vertex_updater (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (vu_start),
        .ev_i        (ev_cur),
        .req_o       (vu_req),
        .req_valid_o (vu_req_valid),
        .done_i      (vu_done),
        .rdata_i     (rdata),
        .fin_o       (vu_fin)
    );

    edge_walker u_edge_walker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (ew_start),
        .ev_i        (ev_cur),
        .req_o       (ew_req),
        .req_valid_o (ew_req_valid),
        .done_i      (ew_done),
        .rdata_i     (rdata),
        .pro_o       (pro_o),
        .pro_valid_o (pro_valid_o),
        .pro_ready_i (pro_ready_i),
        .fin_o       (ew_fin)
    );

    bus_arbiter u_bus_arbiter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .vu_req_i   (vu_req),
        .vu_valid_i (vu_req_valid),
        .vu_done_o  (vu_done),
        .ew_req_i   (ew_req),
        .ew_valid_i (ew_req_valid),
        .ew_done_o  (ew_done),
        .rdata_o    (rdata),
        .paddr_o    (paddr_o),
        .pwrite_o   (pwrite_o),
        .pwdata_o   (pwdata_o),
        .psel_o     (psel_o),
        .penable_o  (penable_o),
        .prdata_i   (prdata_i),
        .pready_i   (pready_i)
    );

endmodule

//--- dv/tb_clkgen.sv
// ====================
// clock and reset for the testbench
// 40 ns period, reset held for ten cycles
// ====================
`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // released on a falling edge like every other input
    initial
    begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- dv/pe_props.sv
// ====================
// handshake assertions, bound into the DUT top
// APB side of the arbiter and propagate side of the edge walker
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module pe_props
    import pe_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_i,
    input logic [`PE_ADDR_W-1:0] paddr_i,
    input logic                  pwrite_i,
    input logic [`PE_DATA_W-1:0] pwdata_i,
    input logic                  psel_i,
    input logic                  penable_i,
    input logic                  pready_i,
    input pe_event_t             pro_i,
    input logic                  pro_valid_i,
    input logic                  pro_ready_i
);

    // request held from setup until the slave is ready
    apb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        psel_i && !pready_i |=> psel_i && $stable(paddr_i) && $stable(pwrite_i)
                                && $stable(pwdata_i))
        else $error("APB request changed before pready");

    // access phase only after a setup cycle
    enable_after_setup: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(penable_i) |-> $past(psel_i) && !$past(penable_i))
        else $error("penable rose without a setup cycle");

    pro_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        pro_valid_i && !pro_ready_i |=> pro_valid_i && $stable(pro_i))
        else $error("propagate event dropped or changed under back-pressure");

endmodule

// the top-level ports are the arbiter's APB outputs and the walker's propagate output
bind pe_top pe_props u_pe_props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .paddr_i     (paddr_o),
    .pwrite_i    (pwrite_o),
    .pwdata_i    (pwdata_o),
    .psel_i      (psel_o),
    .penable_i   (penable_o),
    .pready_i    (pready_i),
    .pro_i       (pro_o),
    .pro_valid_i (pro_valid_o),
    .pro_ready_i (pro_ready_i)
);

//--- dv/pe_tb.sv
// ====================
// testbench of the processing element: APB memory model, reference
// model of value updates and propagate events, directed tests
// ====================
`timescale 1ns/1ps
`include "pe_macros.svh"

module pe_tb
    import pe_pkg::*;
();

    localparam int NUM_V     = 16;
    localparam int MEM_WORDS = 1024;
    // five tests, about 30 events of well under 200 cycles each
    localparam int CYCLE_LIMIT = 20000;

    logic                  clk_i;
    logic                  rst_i;
    pe_event_t             ev_i;
    logic                  ev_valid_i;
    logic                  ev_ready_o;
    pe_event_t             pro_o;
    logic                  pro_valid_o;
    logic                  pro_ready_i;
    logic [`PE_ADDR_W-1:0] paddr_o;
    logic                  pwrite_o;
    logic [`PE_DATA_W-1:0] pwdata_o;
    logic                  psel_o;
    logic                  penable_o;
    logic [`PE_DATA_W-1:0] prdata_i;
    logic                  pready_i;

    logic [`PE_DATA_W-1:0] mem [MEM_WORDS];
    logic [15:0]           ptr [NUM_V+2];
    logic [`PE_IDX_W-1:0]  col [64];
    vertex_val_t           ref_val [NUM_V];
    pe_event_t             exp_q [$];
    integer                seed;
    int                    wait_left;
    logic                  backpressure;
    int                    cycles = 0;

    tb_clkgen u_clkgen (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    pe_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ev_i        (ev_i),
        .ev_valid_i  (ev_valid_i),
        .ev_ready_o  (ev_ready_o),
        .pro_o       (pro_o),
        .pro_valid_o (pro_valid_o),
        .pro_ready_i (pro_ready_i),
        .paddr_o     (paddr_o),
        .pwrite_o    (pwrite_o),
        .pwdata_o    (pwdata_o),
        .psel_o      (psel_o),
        .penable_o   (penable_o),
        .prdata_i    (prdata_i),
        .pready_i    (pready_i)
    );

    // ====================
    // failure and compare tasks
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_event(input string name, input pe_event_t exp, input pe_event_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %0t %s expected idx %0d delta %0d, actual idx %0d delta %0d",
                                $time, name, exp.idx, exp.delta, act.idx, act.delta));
    endtask

    task automatic check_value(input string name, input vertex_val_t exp, input vertex_val_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %0t %s expected %h, actual %h",
                                $time, name, exp, act));
    endtask

    // ====================
    // graph and reference model
    // ====================
    function automatic int degree_of(input int v);
        case (v)
            0, 1, 4, 12, 15: return 2;
            2, 9, 14:        return 3;
            3, 6, 13:        return 1;
            5:               return 5;
            7, 10:           return 0;
            8:               return 4;
            default:         return 6;
        endcase
    endfunction

    task automatic load_graph();
        int a;
        int v;
        int w;
        // every word gets a pattern of its own address
        for (a = 0; a < MEM_WORDS; a++)
            mem[a] = {~a[15:0], a[15:0]};
        ptr[0] = 16'd0;
        for (v = 0; v < NUM_V; v++)
            ptr[v+1] = ptr[v] + 16'(degree_of(v));
        ptr[NUM_V+1] = ptr[NUM_V];
        for (a = 0; a < 64; a++)
            col[a] = 8'((a * 5 + 3) % NUM_V);
        for (w = 0; w < (NUM_V + 2) / 2; w++)
            mem[`PE_ROWPTR_BASE + w] = {ptr[2*w+1], ptr[2*w]};
        for (w = 0; w < 16; w++)
            mem[`PE_COLIDX_BASE + w] = {col[4*w+3], col[4*w+2], col[4*w+1], col[4*w]};
        for (v = 0; v < NUM_V; v++)
            ref_val[v] = mem[`PE_VERTEX_BASE + v][15:0];
    endtask

    task automatic predict(input pe_event_t e);
        int          start;
        int          stop;
        int          p;
        logic [15:0] damped;
        pe_event_t   pe;
        ref_val[e.idx] = ref_val[e.idx] + e.delta;
        if (e.delta > `PE_THRESH)
        begin
            start = ptr[e.idx];
            stop  = ptr[e.idx+1];
            // sink vertex emits nothing
            if (stop > start)
            begin
                damped = 16'((32'(e.delta) * `PE_DAMP) / 256);
                for (p = start; p < stop; p++)
                begin
                    pe.idx   = col[p];
                    pe.delta = 16'(damped / (stop - start));
                    exp_q.push_back(pe);
                end
            end
        end
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic send_event(input logic [7:0] idx, input logic [15:0] delta);
        pe_event_t e;
        e.idx   = idx;
        e.delta = delta;
        predict(e);
        @(negedge clk_i);
        ev_i       = e;
        ev_valid_i = 1'b1;
        while (!ev_ready_o)
            @(negedge clk_i);
        @(negedge clk_i);
        ev_valid_i = 1'b0;
        // ready again once every started worker is done
        while (!ev_ready_o)
            @(negedge clk_i);
    endtask

    task automatic check_results();
        int v;
        if (exp_q.size() != 0)
            abort_run($sformatf("%0d expected propagate events never came out", exp_q.size()));
        for (v = 0; v < NUM_V; v++)
            check_value($sformatf("vertex[%0d]", v), ref_val[v], mem[`PE_VERTEX_BASE + v][15:0]);
    endtask

    // APB slave with 0 to 3 wait states, and the propagate sink
    always @(negedge clk_i)
    begin
        pready_i = 1'b0;
        if (psel_o && (paddr_o >= MEM_WORDS))
            abort_run("APB address outside the memory model");
        if (psel_o && !penable_o)
            wait_left = $random(seed) & 3;
        else if (psel_o && penable_o)
        begin
            if (wait_left == 0)
            begin
                pready_i = 1'b1;
                if (pwrite_o)
                    mem[paddr_o] = pwdata_o;
                else
                    prdata_i = mem[paddr_o];
            end
            else
                wait_left = wait_left - 1;
        end
        pro_ready_i = backpressure ? 1'($random(seed) & 1) : 1'b1;
        // accepted on the coming rising edge
        if (pro_valid_o && pro_ready_i)
        begin
            if (exp_q.size() == 0)
                abort_run("propagate event that the reference model does not expect");
            else
                check_event("pro_o", exp_q.pop_front(), pro_o);
        end
    end

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run("timeout, the DUT stopped making progress");
    end

    // ====================
    // directed tests
    // ====================
    task automatic test_below_threshold();
        load_graph();
        send_event(8'd3, `PE_THRESH);
        send_event(8'd9, 16'd10);
        check_results();
    endtask

    task automatic test_even_one_word();
        load_graph();
        send_event(8'd2, 16'd1000);
        check_results();
    endtask

    task automatic test_odd_two_words();
        load_graph();
        send_event(8'd5, 16'd5000);
        send_event(8'd11, 16'hfff0);
        check_results();
    endtask

    task automatic test_zero_degree();
        load_graph();
        send_event(8'd7, 16'd3000);
        send_event(8'd10, 16'd200);
        check_results();
    endtask

    task automatic test_random_traffic();
        int         n;
        logic [7:0] idx;
        logic [15:0] delta;
        load_graph();
        backpressure = 1'b1;
        for (n = 0; n < 20; n++)
        begin
            idx   = 8'($random(seed) & (NUM_V - 1));
            delta = 16'($random(seed));
            send_event(idx, delta);
        end
        backpressure = 1'b0;
        check_results();
    endtask

    initial
    begin
        seed         = 32'h2f5f4068;
        wait_left    = 0;
        backpressure = 1'b0;
        ev_i         = '0;
        ev_valid_i   = 1'b0;
        pro_ready_i  = 1'b1;
        prdata_i     = '0;
        pready_i     = 1'b0;
        @(negedge clk_i);
        while (rst_i)
            @(negedge clk_i);
        test_below_threshold();
        test_even_one_word();
        test_odd_two_words();
        test_zero_degree();
        test_random_traffic();
        $display("test passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/pe_pkg.sv
rtl/bus_arbiter.sv
rtl/vertex_updater.sv
rtl/edge_walker.sv
rtl/event_ctrl.sv
rtl/pe_top.sv
dv/tb_clkgen.sv
dv/pe_props.sv
dv/pe_tb.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f build.f --top-module pe_tb -Mdir obj_dir \
    && ./obj_dir/Vpe_tb \
    || { echo "simulation did not pass"; exit 1; }
